//--- Makefile
TB := cr_mem_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f src.f --top-module cr_mem

sim:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TB) -o $(TB)
	@out=$$(./obj_dir/$(TB)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- dv/cr_mem_tb.sv
// Testbench for the control register block
// LFSR stimulus on both ports, register map model and read checker
`timescale 1ns/1ps
`default_nettype none

module cr_mem_tb
    import cr_core_pkg::*;
    import cr_map_pkg::*;
();

    localparam int          CLK_PERIOD   = 40;
    localparam int          MAX_CYCLES   = 2000;
    localparam logic [31:0] STACK_SIZE   = 32'h0000_0400;  // DUT defaults
    localparam logic [31:0] SHARED_RESET = 32'h0000_8000;

    logic        clk;
    logic        reset;
    logic [7:0]  core_id_strap;
    logic [3:0]  thread;
    logic [31:0] pc;
    logic [15:0] core_addr;
    logic        core_rd_en;
    logic        core_wr_en;
    logic [31:0] core_wr_data;
    logic [31:0] core_rd_data;
    logic [15:0] ring_addr;
    logic        ring_rd_en;
    logic        ring_wr_en;
    logic [31:0] ring_wr_data;
    logic [31:0] ring_rd_data;
    logic [3:0]  thread_rst;
    logic [3:0]  thread_en;

    // Model of the register map and the view registers
    logic [3:0]  m_rst;
    logic [3:0]  m_en;
    logic [31:0] m_stk [4];
    logic [31:0] m_tls [4];
    logic [31:0] m_ch [4];
    logic [31:0] m_cv [4];
    logic [31:0] m_scr [4];
    logic [31:0] m_shrd;
    logic [1:0]  v_tid;
    logic [31:0] v_stk;
    logic [31:0] v_tls;
    logic [31:0] v_ch;
    logic [31:0] v_cv;
    logic [31:0] v_pc [4];
    logic [7:0]  v_core;

    logic [31:0] exp_core;
    logic [31:0] exp_ring;
    logic [15:0] core_raddr;
    logic [15:0] ring_raddr;
    logic        core_valid = 1'b0;  // Expected value pending for the next check
    logic        ring_valid = 1'b0;
    logic        rotate;
    logic [15:0] lfsr;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;

    cr_mem cr_mem_i (
        .clk           (clk),
        .reset         (reset),
        .core_id_strap (core_id_strap),
        .thread        (thread),
        .pc            (pc),
        .core_addr     (core_addr),
        .core_rd_en    (core_rd_en),
        .core_wr_en    (core_wr_en),
        .core_wr_data  (core_wr_data),
        .core_rd_data  (core_rd_data),
        .ring_addr     (ring_addr),
        .ring_rd_en    (ring_rd_en),
        .ring_wr_en    (ring_wr_en),
        .ring_wr_data  (ring_wr_data),
        .ring_rd_data  (ring_rd_data),
        .thread_rst    (thread_rst),
        .thread_en     (thread_en)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] next_rand(input int nbits);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic logic [15:0] writable_addr();
        return 16'(32'd5 + next_rand(6) % 32'd31);  // 0x05 to 0x23
    endfunction

    function automatic int thread_index(input logic [3:0] mark);
        int idx;
        idx = 0;
        for (int i = 0; i < 4; i++) begin
            if (mark[i]) idx = i;
        end
        return idx;
    endfunction

    // Expected read data by groups of four addresses
    function automatic logic [31:0] ref_read(input logic [15:0] addr);
        logic [31:0] word;
        int          n;
        word = '0;
        n    = int'(addr[1:0]);
        if (addr < 16'h0028) begin
            case (addr[5:2])
                4'd0: begin
                    case (n)
                        0:       word = {22'd0, v_core, v_tid};  // Who am I
                        1:       word = {30'd0, v_tid};
                        2:       word = {24'd0, v_core};
                        default: word = v_stk;
                    endcase
                end
                4'd1: begin
                    case (n)
                        0:       word = v_tls;
                        1:       word = v_ch;
                        2:       word = v_cv;
                        default: word = m_shrd;
                    endcase
                end
                4'd2:    word = {31'd0, m_rst[n]};
                4'd3:    word = {31'd0, m_en[n]};
                4'd4:    word = m_stk[n];
                4'd5:    word = m_tls[n];
                4'd6:    word = m_ch[n];
                4'd7:    word = m_cv[n];
                4'd8:    word = m_scr[n];
                default: word = v_pc[n];
            endcase
        end
        return word;
    endfunction

    task automatic apply_write(input logic [15:0] addr, input logic [31:0] data, input int cur);
        int n;
        n = int'(addr[1:0]);
        case (addr[5:2])
            4'd1: begin
                case (n)
                    1:       m_ch[cur] = data;  // Aliased cursors
                    2:       m_cv[cur] = data;
                    3:       m_shrd    = data;
                    default: ;
                endcase
            end
            4'd2:    m_rst[n] = data[0];
            4'd3:    m_en[n]  = data[0];
            4'd4:    m_stk[n] = data;
            4'd5:    m_tls[n] = data;
            4'd6:    m_ch[n]  = data;
            4'd7:    m_cv[n]  = data;
            4'd8:    m_scr[n] = data;
            default: ;
        endcase
    endtask

    task automatic reset_model();
        m_rst  = '0;
        m_en   = '1;
        m_shrd = SHARED_RESET;
        v_tid  = '0;
        v_stk  = '0;
        v_tls  = '0;
        v_ch   = '0;
        v_cv   = '0;
        v_core = '0;
        for (int t = 0; t < 4; t++) begin
            m_stk[t] = 32'(t) * STACK_SIZE;
            m_tls[t] = 32'(t) * STACK_SIZE;
            m_ch[t]  = '0;
            m_cv[t]  = '0;
            m_scr[t] = '0;
            v_pc[t]  = '0;
        end
    endtask

    // ========================================
    // Checker at the falling edge where outputs are stable
    // ========================================
    always @(negedge clk) begin : compare_model
        int cur;
        int nxt;
        if (core_valid) begin
            checks++;
            assert (core_rd_data === exp_core) else begin
                $display("[ERROR] core_rd_data at %h: got %h, expected %h",
                         core_raddr, core_rd_data, exp_core);
                errors++;
            end
        end
        if (ring_valid) begin
            checks++;
            assert (ring_rd_data === exp_ring) else begin
                $display("[ERROR] ring_rd_data at %h: got %h, expected %h",
                         ring_raddr, ring_rd_data, exp_ring);
                errors++;
            end
        end
        if (!reset) begin
            checks += 2;
            assert (thread_rst === m_rst) else begin
                $display("[ERROR] thread_rst: got %h, expected %h", thread_rst, m_rst);
                errors++;
            end
            assert (thread_en === m_en) else begin
                $display("[ERROR] thread_en: got %h, expected %h", thread_en, m_en);
                errors++;
            end
        end
        if (reset) begin
            reset_model();
            core_valid = 1'b0;
            ring_valid = 1'b0;
        end else begin
            exp_core   = core_rd_en ? ref_read(core_addr) : '0;
            exp_ring   = ring_rd_en ? ref_read(ring_addr) : '0;
            core_raddr = core_addr;
            ring_raddr = ring_addr;
            core_valid = 1'b1;
            ring_valid = 1'b1;
            cur = thread_index(thread);
            nxt = (cur + 1) % NUM_THREADS;  // View follows the next thread
            v_tid     = 2'(nxt);
            v_stk     = m_stk[nxt];
            v_tls     = m_tls[nxt];
            v_ch      = m_ch[nxt];
            v_cv      = m_cv[nxt];
            v_pc[nxt] = pc;
            v_core    = core_id_strap;
            if (core_wr_en) apply_write(core_addr, core_wr_data, cur);
            if (ring_wr_en) apply_write(ring_addr, ring_wr_data, cur);  // Ring lands last
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped at the cycle limit of %0d", MAX_CYCLES);
            $display("checks %0d, errors %0d", checks, errors);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic drive_ports(input logic [15:0] c_addr, input logic c_rd, input logic c_wr,
                               input logic [31:0] c_data, input logic [15:0] r_addr,
                               input logic r_rd, input logic r_wr, input logic [31:0] r_data);
        @(posedge clk);
        core_addr    <= c_addr;
        core_rd_en   <= c_rd;
        core_wr_en   <= c_wr;
        core_wr_data <= c_data;
        ring_addr    <= r_addr;
        ring_rd_en   <= r_rd;
        ring_wr_en   <= r_wr;
        ring_wr_data <= r_data;
        if (rotate) begin
            thread <= {thread[2:0], thread[3]};
            pc     <= next_rand(32);
        end
    endtask

    task automatic idle_cycle();
        drive_ports(16'h0, 1'b0, 1'b0, 32'h0, 16'h0, 1'b0, 1'b0, 32'h0);
    endtask

    task automatic core_write(input logic [15:0] addr, input logic [31:0] data);
        drive_ports(addr, 1'b0, 1'b1, data, 16'h0, 1'b0, 1'b0, 32'h0);
    endtask

    task automatic ring_write(input logic [15:0] addr, input logic [31:0] data);
        drive_ports(16'h0, 1'b0, 1'b0, 32'h0, addr, 1'b0, 1'b1, data);
    endtask

    task automatic read_both(input logic [15:0] c_addr, input logic [15:0] r_addr);
        drive_ports(c_addr, 1'b1, 1'b0, 32'h0, r_addr, 1'b1, 1'b0, 32'h0);
    endtask

    // ========================================
    // Stimulus
    // ========================================
    initial begin : stimulus
        logic [15:0] addr;
        logic [31:0] data_a;
        logic [31:0] data_b;
        lfsr          = 16'd12;
        rotate        = 1'b0;
        reset         = 1'b1;
        thread        = 4'b0001;
        pc            = '0;
        core_id_strap = 8'h5A;
        core_addr     = '0;
        core_rd_en    = 1'b0;
        core_wr_en    = 1'b0;
        core_wr_data  = '0;
        ring_addr     = '0;
        ring_rd_en    = 1'b0;
        ring_wr_en    = 1'b0;
        ring_wr_data  = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        for (int a = 0; a < 16'h0028; a++) begin
            read_both(16'(a), 16'(16'h0027 - a));  // Whole map after reset
        end

        for (int i = 0; i < 40; i++) begin
            addr   = writable_addr();
            data_a = next_rand(32);
            if (i % 2 == 0) begin
                core_write(addr, data_a);
                read_both(16'h0, addr);
            end else begin
                ring_write(addr, data_a);
                read_both(addr, 16'h0);
            end
        end
        repeat (8) begin
            addr = 16'(32'h28 + next_rand(15));
            read_both(addr, ~addr);  // Unmapped on both ports
            idle_cycle();
        end

        repeat (6) begin
            addr   = writable_addr();
            data_a = next_rand(32);
            data_b = next_rand(32);
            drive_ports(addr, 1'b0, 1'b1, data_a, addr, 1'b0, 1'b1, data_b);
            read_both(addr, addr);
        end
        drive_ports(CR_SCRATCHPAD0, 1'b0, 1'b1, next_rand(32),
                    CR_SCRATCHPAD3, 1'b0, 1'b1, next_rand(32));
        read_both(CR_SCRATCHPAD0, CR_SCRATCHPAD3);

        for (int t = 0; t < 4; t++) begin
            idle_cycle();
            thread <= 4'(1 << t);
            core_write(CR_CURSOR_H, next_rand(32));
            ring_write(CR_CURSOR_V, next_rand(32));
            read_both(16'(CR_CURSOR_H0 + t), 16'(CR_CURSOR_V0 + t));
            read_both(CR_CURSOR_H, CR_STACK_BASE_OFFSET);
            read_both(CR_THREAD_ID, CR_CURSOR_V);
        end

        rotate = 1'b1;  // Thread mark and pc change every cycle from here
        repeat (8) idle_cycle();
        for (int t = 0; t < 4; t++) begin
            read_both(16'(CR_THREAD0_PC + t), 16'(CR_THREAD3_PC - t));
        end
        core_write(CR_THREAD2_PC_RST, 32'h0000_0001);
        ring_write(CR_THREAD1_PC_EN, 32'h0000_0000);
        core_write(CR_THREAD0_PC_EN, 32'hFFFF_FFFE);  // Only bit 0 counts
        read_both(CR_THREAD2_PC_RST, CR_THREAD0_PC_EN);

        for (int i = 0; i < 4; i++) begin
            idle_cycle();
            core_id_strap <= 8'(next_rand(8));
            read_both(CR_CORE_ID, CR_WHO_AM_I);
            read_both(CR_WHO_AM_I, CR_THREAD_ID);
        end
        rotate = 1'b0;

        idle_cycle();
        idle_cycle();
        @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/cr_core_pkg.sv
// Shared widths, thread ids and the register bundles passed
// between the write decode, register, capture and read blocks
`default_nettype none

package cr_core_pkg;

    localparam int CR_DATA_W   = 32;  // Register and bus width
    localparam int CR_ADDR_W   = 16;
    localparam int NUM_THREADS = 4;   // Barrel depth
    localparam int NUM_SCRATCH = 4;

    typedef enum logic [1:0] {
        T0,
        T1,
        T2,
        T3
    } thread_id_e;

    typedef logic [CR_DATA_W-1:0] cr_word_t;
    typedef logic [7:0]           core_id_t;  // Strap value width

    // One enable per writable register
    typedef struct packed {
        logic [NUM_THREADS-1:0] rst_pc;
        logic [NUM_THREADS-1:0] en_pc;
        logic [NUM_THREADS-1:0] stk_ofst;
        logic [NUM_THREADS-1:0] tls_ofst;
        logic [NUM_THREADS-1:0] cursor_h;
        logic [NUM_THREADS-1:0] cursor_v;
        logic                   shrd_ofst;
        logic [NUM_SCRATCH-1:0] scratch_pad;
    } cr_wr_en_t;

    // Software-written register contents
    typedef struct packed {
        logic [NUM_THREADS-1:0]     rst_pc;
        logic [NUM_THREADS-1:0]     en_pc;
        cr_word_t [NUM_THREADS-1:0] stk_ofst;
        cr_word_t [NUM_THREADS-1:0] tls_ofst;
        cr_word_t [NUM_THREADS-1:0] cursor_h;
        cr_word_t [NUM_THREADS-1:0] cursor_v;
        cr_word_t                   shrd_ofst;
        cr_word_t [NUM_SCRATCH-1:0] scratch_pad;
    } cr_rw_t;

    // Hardware-written view of the next thread in the rotation
    typedef struct packed {
        thread_id_e                 thread_id;
        cr_word_t                   stk_ofst;
        cr_word_t                   tls_ofst;
        cr_word_t                   cursor_h;
        cr_word_t                   cursor_v;
        cr_word_t [NUM_THREADS-1:0] pc;
        core_id_t                   core_id;
    } cr_view_t;

endpackage

`default_nettype wire

//--- logic/cr_hw_capture.sv
// Hardware view registers for the next thread in the barrel
// Per-thread pc capture and core id strap
`timescale 1ns/1ps
`default_nettype none

module cr_hw_capture
    import cr_core_pkg::*;
    import cr_map_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire [NUM_THREADS-1:0] thread,         // One-hot running thread
    input  wire [CR_DATA_W-1:0]   pc,
    input  wire [CORE_ID_W-1:0]   core_id_strap,
    input  wire cr_rw_t           regs,
    output cr_view_t              view
);

    logic [NUM_THREADS-1:0] next_thread;  // Mark rotated by one
    thread_id_e             next_id;

    assign next_thread = {thread[NUM_THREADS-2:0], thread[NUM_THREADS-1]};

    always_comb begin
        next_id = T0;
        for (int t = 0; t < NUM_THREADS; t++) begin
            if (next_thread[t]) next_id = thread_id_e'(t[1:0]);
        end
    end

    // ========================================
    // View registers updated every cycle
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            view <= '0;
        end else begin
            view.thread_id   <= next_id;
            view.stk_ofst    <= regs.stk_ofst[next_id];
            view.tls_ofst    <= regs.tls_ofst[next_id];
            view.cursor_h    <= regs.cursor_h[next_id];
            view.cursor_v    <= regs.cursor_v[next_id];
            view.pc[next_id] <= pc;             // Other slots hold
            view.core_id     <= core_id_strap;
        end
    end

    // The core drives exactly one thread mark per cycle
    thread_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(thread))
        else $error("thread mark %b is not one-hot", thread);

endmodule

`default_nettype wire

//--- logic/cr_map_pkg.sv
// Register address map and narrow field widths
`default_nettype none

package cr_map_pkg;

    import cr_core_pkg::*;

    localparam int CORE_ID_W = $bits(core_id_t);

    // Per-thread groups start on a multiple of four, so addr[1:0] is the thread
    typedef enum logic [CR_ADDR_W-1:0] {
        // ========================================
        // View and shared registers
        // ========================================
        CR_WHO_AM_I                  = 16'h0000,  // Core id above thread id
        CR_THREAD_ID                 = 16'h0001,
        CR_CORE_ID                   = 16'h0002,
        CR_STACK_BASE_OFFSET         = 16'h0003,  // Next thread's copy
        CR_TLS_BASE_OFFSET           = 16'h0004,
        CR_CURSOR_H                  = 16'h0005,  // Alias of the running thread's copy
        CR_CURSOR_V                  = 16'h0006,
        CR_SHARED_BASE_OFFSET        = 16'h0007,
        // ========================================
        // Per-thread groups
        // ========================================
        CR_THREAD0_PC_RST            = 16'h0008,
        CR_THREAD1_PC_RST,
        CR_THREAD2_PC_RST,
        CR_THREAD3_PC_RST,
        CR_THREAD0_PC_EN             = 16'h000C,
        CR_THREAD1_PC_EN,
        CR_THREAD2_PC_EN,
        CR_THREAD3_PC_EN,
        CR_THREAD0_STACK_BASE_OFFSET = 16'h0010,
        CR_THREAD1_STACK_BASE_OFFSET,
        CR_THREAD2_STACK_BASE_OFFSET,
        CR_THREAD3_STACK_BASE_OFFSET,
        CR_THREAD0_TLS_BASE_OFFSET   = 16'h0014,
        CR_THREAD1_TLS_BASE_OFFSET,
        CR_THREAD2_TLS_BASE_OFFSET,
        CR_THREAD3_TLS_BASE_OFFSET,
        CR_CURSOR_H0                 = 16'h0018,
        CR_CURSOR_H1,
        CR_CURSOR_H2,
        CR_CURSOR_H3,
        CR_CURSOR_V0                 = 16'h001C,
        CR_CURSOR_V1,
        CR_CURSOR_V2,
        CR_CURSOR_V3,
        CR_SCRATCHPAD0               = 16'h0020,
        CR_SCRATCHPAD1,
        CR_SCRATCHPAD2,
        CR_SCRATCHPAD3,
        CR_THREAD0_PC                = 16'h0024,  // Read-only captured pc
        CR_THREAD1_PC,
        CR_THREAD2_PC,
        CR_THREAD3_PC
    } cr_addr_e;

endpackage

`default_nettype wire

//--- logic/cr_mem.sv
// Control register block of the barrel core
// Core and ring access ports, thread reset and enable outputs
`timescale 1ns/1ps
`default_nettype none

module cr_mem
    import cr_core_pkg::*;
    import cr_map_pkg::*;
#(
    parameter logic [CR_DATA_W-1:0] STACK_REGION_SIZE   = 32'h0000_0400,
    parameter logic [CR_DATA_W-1:0] SHARED_OFFSET_RESET = 32'h0000_8000
)(
    input  wire                    clk,
    input  wire                    reset,
    input  wire  [CORE_ID_W-1:0]   core_id_strap,
    input  wire  [NUM_THREADS-1:0] thread,        // One-hot running thread
    input  wire  [CR_DATA_W-1:0]   pc,
    // Core side
    input  wire  [CR_ADDR_W-1:0]   core_addr,
    input  wire                    core_rd_en,
    input  wire                    core_wr_en,
    input  wire  [CR_DATA_W-1:0]   core_wr_data,
    output logic [CR_DATA_W-1:0]   core_rd_data,
    // Ring side
    input  wire  [CR_ADDR_W-1:0]   ring_addr,
    input  wire                    ring_rd_en,
    input  wire                    ring_wr_en,
    input  wire  [CR_DATA_W-1:0]   ring_wr_data,
    output logic [CR_DATA_W-1:0]   ring_rd_data,
    output logic [NUM_THREADS-1:0] thread_rst,
    output logic [NUM_THREADS-1:0] thread_en
);

    cr_port_if core_port ();
    cr_port_if ring_port ();

    cr_wr_en_t wr_en;
    cr_wr_en_t wr_sel;
    cr_rw_t    regs;
    cr_view_t  view;

    // ========================================
    // Port bundles
    // ========================================
    assign core_port.addr    = core_addr;
    assign core_port.rd_en   = core_rd_en;
    assign core_port.wr_en   = core_wr_en;
    assign core_port.wr_data = core_wr_data;
    assign core_rd_data      = core_port.rd_data;

    assign ring_port.addr    = ring_addr;
    assign ring_port.rd_en   = ring_rd_en;
    assign ring_port.wr_en   = ring_wr_en;
    assign ring_port.wr_data = ring_wr_data;
    assign ring_rd_data      = ring_port.rd_data;

    cr_write_decode write_decode_i (
        .core_port (core_port),
        .ring_port (ring_port),
        .thread    (thread),
        .wr_en     (wr_en),
        .wr_sel    (wr_sel)
    );

    cr_thread_regs #(
        .STACK_REGION_SIZE   (STACK_REGION_SIZE),
        .SHARED_OFFSET_RESET (SHARED_OFFSET_RESET)
    ) thread_regs_i (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .wr_sel       (wr_sel),
        .core_wr_data (core_port.wr_data),
        .ring_wr_data (ring_port.wr_data),
        .regs         (regs)
    );

    cr_hw_capture hw_capture_i (
        .clk           (clk),
        .reset         (reset),
        .thread        (thread),
        .pc            (pc),
        .core_id_strap (core_id_strap),
        .regs          (regs),
        .view          (view)
    );

    cr_read_mux read_mux_i (
        .clk       (clk),
        .core_port (core_port),
        .ring_port (ring_port),
        .regs      (regs),
        .view      (view)
    );

    assign thread_rst = regs.rst_pc;
    assign thread_en  = regs.en_pc;

endmodule

`default_nettype wire

//--- logic/cr_port_if.sv
// One register access port, seen by the write decode and the read mux
`timescale 1ns/1ps
`default_nettype none

interface cr_port_if
    import cr_core_pkg::*;
();

    logic [CR_ADDR_W-1:0] addr;
    logic                 rd_en;    // Read strobe, data one cycle later
    logic                 wr_en;    // Write strobe, lands at the next edge
    logic [CR_DATA_W-1:0] wr_data;
    logic [CR_DATA_W-1:0] rd_data;

    modport decode (
        input addr,
        input wr_en,
        input wr_data
    );

    modport reader (
        input  addr,
        input  rd_en,
        output rd_data
    );

endinterface

`default_nettype wire

//--- logic/cr_read_mux.sv
// Read address decode and registered read data for both ports
`timescale 1ns/1ps
`default_nettype none

module cr_read_mux
    import cr_core_pkg::*;
    import cr_map_pkg::*;
(
    input  wire            clk,
    cr_port_if.reader      core_port,
    cr_port_if.reader      ring_port,
    input  wire cr_rw_t    regs,
    input  wire cr_view_t  view
);

    function automatic logic [CR_DATA_W-1:0] read_word(input logic [CR_ADDR_W-1:0] addr);
        logic [CR_DATA_W-1:0] data;
        logic [1:0]           idx;
        idx  = addr[1:0];  // Thread or scratchpad within a group
        data = '0;
        case (addr) inside
            CR_WHO_AM_I           : data = CR_DATA_W'({view.core_id, view.thread_id});
            CR_THREAD_ID          : data = CR_DATA_W'(view.thread_id);
            CR_CORE_ID            : data = CR_DATA_W'(view.core_id);
            CR_STACK_BASE_OFFSET  : data = view.stk_ofst;
            CR_TLS_BASE_OFFSET    : data = view.tls_ofst;
            CR_CURSOR_H           : data = view.cursor_h;
            CR_CURSOR_V           : data = view.cursor_v;
            CR_SHARED_BASE_OFFSET : data = regs.shrd_ofst;
            [CR_THREAD0_PC_RST : CR_THREAD3_PC_RST] :
                data = CR_DATA_W'(regs.rst_pc[idx]);
            [CR_THREAD0_PC_EN : CR_THREAD3_PC_EN] :
                data = CR_DATA_W'(regs.en_pc[idx]);
            [CR_THREAD0_STACK_BASE_OFFSET : CR_THREAD3_STACK_BASE_OFFSET] :
                data = regs.stk_ofst[idx];
            [CR_THREAD0_TLS_BASE_OFFSET : CR_THREAD3_TLS_BASE_OFFSET] :
                data = regs.tls_ofst[idx];
            [CR_CURSOR_H0 : CR_CURSOR_H3] :
                data = regs.cursor_h[idx];
            [CR_CURSOR_V0 : CR_CURSOR_V3] :
                data = regs.cursor_v[idx];
            [CR_SCRATCHPAD0 : CR_SCRATCHPAD3] :
                data = regs.scratch_pad[idx];
            [CR_THREAD0_PC : CR_THREAD3_PC] :
                data = view.pc[idx];
            default               : data = '0;  // Unmapped
        endcase
        return data;
    endfunction

    // ========================================
    // One cycle read with zero when idle
    // ========================================
    always_ff @(posedge clk) begin
        core_port.rd_data <= core_port.rd_en ? read_word(core_port.addr) : '0;
        ring_port.rd_data <= ring_port.rd_en ? read_word(ring_port.addr) : '0;
    end

endmodule

`default_nettype wire

//--- logic/cr_thread_regs.sv
// Software-writable control registers with their reset values
`timescale 1ns/1ps
`default_nettype none

module cr_thread_regs
    import cr_core_pkg::*;
#(
    parameter logic [CR_DATA_W-1:0] STACK_REGION_SIZE   = 32'h0000_0400,
    parameter logic [CR_DATA_W-1:0] SHARED_OFFSET_RESET = 32'h0000_8000
)(
    input  wire                 clk,
    input  wire                 reset,
    input  wire cr_wr_en_t      wr_en,
    input  wire cr_wr_en_t      wr_sel,        // 1 selects ring data
    input  wire [CR_DATA_W-1:0] core_wr_data,
    input  wire [CR_DATA_W-1:0] ring_wr_data,
    output cr_rw_t              regs
);

    logic [CR_DATA_W-1:0] wr_word [2];  // Indexed by the select bit

    assign wr_word[0] = core_wr_data;
    assign wr_word[1] = ring_wr_data;

    // ========================================
    // Register update
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            regs.rst_pc      <= '0;
            regs.en_pc       <= '1;  // All threads enabled out of reset
            regs.cursor_h    <= '0;
            regs.cursor_v    <= '0;
            regs.shrd_ofst   <= SHARED_OFFSET_RESET;
            regs.scratch_pad <= '0;
            for (int t = 0; t < NUM_THREADS; t++) begin
                regs.stk_ofst[t] <= CR_DATA_W'(t) * STACK_REGION_SIZE;
                regs.tls_ofst[t] <= CR_DATA_W'(t) * STACK_REGION_SIZE;
            end
        end else begin
            for (int t = 0; t < NUM_THREADS; t++) begin
                if (wr_en.rst_pc[t]) begin
                    regs.rst_pc[t] <= wr_word[wr_sel.rst_pc[t]][0];
                end
                if (wr_en.en_pc[t]) begin
                    regs.en_pc[t] <= wr_word[wr_sel.en_pc[t]][0];
                end
                if (wr_en.stk_ofst[t]) begin
                    regs.stk_ofst[t] <= wr_word[wr_sel.stk_ofst[t]];
                end
                if (wr_en.tls_ofst[t]) begin
                    regs.tls_ofst[t] <= wr_word[wr_sel.tls_ofst[t]];
                end
                if (wr_en.cursor_h[t]) begin
                    regs.cursor_h[t] <= wr_word[wr_sel.cursor_h[t]];
                end
                if (wr_en.cursor_v[t]) begin
                    regs.cursor_v[t] <= wr_word[wr_sel.cursor_v[t]];
                end
            end
            for (int s = 0; s < NUM_SCRATCH; s++) begin
                if (wr_en.scratch_pad[s]) begin
                    regs.scratch_pad[s] <= wr_word[wr_sel.scratch_pad[s]];
                end
            end
            if (wr_en.shrd_ofst) begin
                regs.shrd_ofst <= wr_word[wr_sel.shrd_ofst];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/cr_write_decode.sv
// Write address decode for the core and ring ports
// Merged enables and the ring-wins data select
`timescale 1ns/1ps
`default_nettype none

module cr_write_decode
    import cr_core_pkg::*;
    import cr_map_pkg::*;
(
    cr_port_if.decode                   core_port,
    cr_port_if.decode                   ring_port,
    input  wire [NUM_THREADS-1:0]       thread,     // One-hot running thread
    output cr_wr_en_t                   wr_en,
    output cr_wr_en_t                   wr_sel
);

    cr_wr_en_t core_en;
    cr_wr_en_t ring_en;

    function automatic cr_wr_en_t decode_wr(
        input logic                   wr,
        input logic [CR_ADDR_W-1:0]   addr,
        input logic [NUM_THREADS-1:0] thr
    );
        cr_wr_en_t en;
        en = '0;
        if (wr) begin
            case (addr) inside
                CR_CURSOR_H           : en.cursor_h  = thr;  // Alias follows the thread mark
                CR_CURSOR_V           : en.cursor_v  = thr;
                CR_SHARED_BASE_OFFSET : en.shrd_ofst = 1'b1;
                [CR_THREAD0_PC_RST : CR_THREAD3_PC_RST] :
                    en.rst_pc[addr[1:0]] = 1'b1;
                [CR_THREAD0_PC_EN : CR_THREAD3_PC_EN] :
                    en.en_pc[addr[1:0]] = 1'b1;
                [CR_THREAD0_STACK_BASE_OFFSET : CR_THREAD3_STACK_BASE_OFFSET] :
                    en.stk_ofst[addr[1:0]] = 1'b1;
                [CR_THREAD0_TLS_BASE_OFFSET : CR_THREAD3_TLS_BASE_OFFSET] :
                    en.tls_ofst[addr[1:0]] = 1'b1;
                [CR_CURSOR_H0 : CR_CURSOR_H3] :
                    en.cursor_h[addr[1:0]] = 1'b1;
                [CR_CURSOR_V0 : CR_CURSOR_V3] :
                    en.cursor_v[addr[1:0]] = 1'b1;
                [CR_SCRATCHPAD0 : CR_SCRATCHPAD3] :
                    en.scratch_pad[addr[1:0]] = 1'b1;
                default : ;  // Read-only and unmapped addresses ignored
            endcase
        end
        return en;
    endfunction

    function automatic logic writable(input logic [CR_ADDR_W-1:0] addr);
        return addr inside {CR_CURSOR_H, CR_CURSOR_V,
                            [CR_SHARED_BASE_OFFSET : CR_SCRATCHPAD3]};
    endfunction

    assign core_en = decode_wr(core_port.wr_en, core_port.addr, thread);
    assign ring_en = decode_wr(ring_port.wr_en, ring_port.addr, thread);

    assign wr_en  = core_en | ring_en;
    assign wr_sel = ring_en;  // Ring data taken where the ring writes

    // Software on either side must only write the writable part of the map
    always_comb begin
        core_wr_map: assert final (!core_port.wr_en || writable(core_port.addr))
            else $error("core write to non-writable address %h", core_port.addr);
        ring_wr_map: assert final (!ring_port.wr_en || writable(ring_port.addr))
            else $error("ring write to non-writable address %h", ring_port.addr);
    end

endmodule

`default_nettype wire

//--- src.f
logic/cr_core_pkg.sv
logic/cr_map_pkg.sv
logic/cr_port_if.sv
logic/cr_write_decode.sv
logic/cr_thread_regs.sv
logic/cr_hw_capture.sv
logic/cr_read_mux.sv
logic/cr_mem.sv
dv/cr_mem_tb.sv
